// ==== hw/ex_pkg.sv ====
package ex_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int unsigned XLEN          = 32;
    localparam int unsigned TRANS_ID_BITS = 3;

    // ----------------------------------------
    // Opcodes
    // ----------------------------------------
    typedef enum logic [3:0] {
        ADD = 4'd0,
        SUB = 4'd1,
        AND = 4'd2,
        OR  = 4'd3,
        XOR = 4'd4,
        SLL = 4'd5,
        SRL = 4'd6,
        SLT = 4'd7,
        // Iterative, low word of the product
        MUL = 4'd8
    } fu_op_e;

    // ----------------------------------------
    // Issue and writeback payloads
    // ----------------------------------------
    typedef struct packed {
        fu_op_e                   operator;
        logic [TRANS_ID_BITS-1:0] trans_id;
        logic [XLEN-1:0]          operand_a;
        logic [XLEN-1:0]          operand_b;
    } fu_data_t;

    typedef struct packed {
        logic [TRANS_ID_BITS-1:0] trans_id;
        logic [XLEN-1:0]          result;
    } wb_data_t;

endpackage

// ==== hw/issue_dispatch.sv ====
`timescale 1ns/1ps

module issue_dispatch #(
    parameter int unsigned NUM_LANES = 4
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 issue_req_i,
    input  ex_pkg::fu_data_t     issue_data_i,
    output logic                 issue_ack_o,
    input  logic [NUM_LANES-1:0] lane_busy_i,
    output logic [NUM_LANES-1:0] lane_start_o,
    output ex_pkg::fu_data_t     lane_data_o
);

    localparam int unsigned LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    typedef enum logic [1:0] {
        IDLE,
        ACK,
        WAIT_LOW
    } disp_state_e;

    disp_state_e       state_q;
    logic              free_found;
    logic [LANE_W-1:0] free_idx;
    logic              take;

    // Lowest-numbered idle lane wins
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = NUM_LANES - 1; i >= 0; i--) begin
            if (!lane_busy_i[i]) begin
                free_found = 1'b1;
                free_idx   = LANE_W'(i);
            end
        end
    end

    assign take = (state_q == IDLE) && issue_req_i && free_found;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q      <= IDLE;
            issue_ack_o  <= 1'b0;
            lane_start_o <= '0;
        end else begin
            // Start is a one-cycle pulse
            lane_start_o <= '0;
            case (state_q)
                IDLE: begin
                    if (take) begin
                        issue_ack_o            <= 1'b1;
                        lane_start_o[free_idx] <= 1'b1;
                        state_q                <= ACK;
                    end
                end
                ACK: begin
                    // Requester may already have let go of req
                    if (!issue_req_i) begin
                        issue_ack_o <= 1'b0;
                        state_q     <= IDLE;
                    end else begin
                        state_q <= WAIT_LOW;
                    end
                end
                WAIT_LOW: begin
                    if (!issue_req_i) begin
                        issue_ack_o <= 1'b0;
                        state_q     <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Shared operation bus, stable while start is high
    always_ff @(posedge clk_i) begin
        if (take) begin
            lane_data_o <= issue_data_i;
        end
    end

    // A start never lands on a lane that is still working
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (lane_start_o & lane_busy_i) == '0)
        else $error("issue_dispatch: start sent to a busy lane");

endmodule

// ==== hw/exec_lane.sv ====
`timescale 1ns/1ps

module exec_lane (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             start_i,
    input  ex_pkg::fu_data_t op_i,
    input  logic             release_i,
    output logic             busy_o,
    output logic             done_o,
    output ex_pkg::wb_data_t result_o
);
    import ex_pkg::*;

    localparam int unsigned CNT_W = $clog2(XLEN);

    typedef enum logic [1:0] {
        IDLE,
        MUL_RUN,
        DONE
    } lane_state_e;

    lane_state_e      state_q;
    logic [CNT_W-1:0] cnt_q;
    logic [XLEN-1:0]  mcand_q;
    logic [XLEN-1:0]  mplier_q;
    wb_data_t         res_q;
    logic [XLEN-1:0]  alu_result;
    logic [XLEN-1:0]  mul_term;
    logic [CNT_W-1:0] shamt;
    logic             take;
    logic             is_mul;

    assign take   = (state_q == IDLE) && start_i;
    assign is_mul = (op_i.operator == MUL);
    assign shamt  = op_i.operand_b[CNT_W-1:0];

    // ----------------------------------------
    // Single-cycle ALU
    // ----------------------------------------
    always_comb begin
        case (op_i.operator)
            ADD:     alu_result = op_i.operand_a + op_i.operand_b;
            SUB:     alu_result = op_i.operand_a - op_i.operand_b;
            AND:     alu_result = op_i.operand_a & op_i.operand_b;
            OR:      alu_result = op_i.operand_a | op_i.operand_b;
            XOR:     alu_result = op_i.operand_a ^ op_i.operand_b;
            SLL:     alu_result = op_i.operand_a << shamt;
            SRL:     alu_result = op_i.operand_a >> shamt;
            SLT: begin
                alu_result = {{(XLEN-1){1'b0}},
                              $signed(op_i.operand_a) < $signed(op_i.operand_b)};
            end
            default: alu_result = '0;
        endcase
    end

    // Partial product for the current multiplier bit
    assign mul_term = mplier_q[0] ? mcand_q : '0;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (take && is_mul) begin
                        // Bit 0 is folded into the load, 31 bits remain
                        cnt_q   <= CNT_W'(XLEN - 2);
                        state_q <= MUL_RUN;
                    end else if (take) begin
                        state_q <= DONE;
                    end
                end
                MUL_RUN: begin
                    cnt_q <= cnt_q - 1'b1;
                    if (cnt_q == '0) begin
                        state_q <= DONE;
                    end
                end
                DONE: begin
                    if (release_i) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Hold register doubles as the shift-add accumulator
    always_ff @(posedge clk_i) begin
        if (take) begin
            res_q.trans_id <= op_i.trans_id;
            if (is_mul) begin
                res_q.result <= op_i.operand_b[0] ? op_i.operand_a : '0;
                mcand_q      <= op_i.operand_a << 1;
                mplier_q     <= op_i.operand_b >> 1;
            end else begin
                res_q.result <= alu_result;
            end
        end else if (state_q == MUL_RUN) begin
            res_q.result <= res_q.result + mul_term;
            mcand_q      <= mcand_q << 1;
            mplier_q     <= mplier_q >> 1;
        end
    end

    assign busy_o   = (state_q != IDLE);
    assign done_o   = (state_q == DONE);
    assign result_o = res_q;

    // Dispatcher and arbiter must follow the lane state
    assert property (@(posedge clk_i) disable iff (!rst_ni) start_i |-> state_q == IDLE)
        else $error("exec_lane: start while lane not idle");
    assert property (@(posedge clk_i) disable iff (!rst_ni) release_i |-> state_q == DONE)
        else $error("exec_lane: release before result is done");

endmodule

// ==== hw/wb_arbiter.sv ====
`timescale 1ns/1ps

module wb_arbiter #(
    parameter int unsigned NUM_LANES = 4
) (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic [NUM_LANES-1:0]             lane_done_i,
    input  ex_pkg::wb_data_t [NUM_LANES-1:0] lane_result_i,
    output logic [NUM_LANES-1:0]             lane_release_o,
    output logic                             wb_req_o,
    output ex_pkg::wb_data_t                 wb_data_o,
    input  logic                             wb_ack_i
);

    localparam int unsigned LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    typedef enum logic [1:0] {
        WB_IDLE,
        WB_REQ,
        WB_ACK_LOW
    } wb_state_e;

    wb_state_e         state_q;
    logic [LANE_W-1:0] last_q;
    logic              pick_valid;
    logic [LANE_W-1:0] pick_idx;
    logic              grant;

    // ----------------------------------------
    // Round-robin, search starts after last served
    // ----------------------------------------
    always_comb begin
        int unsigned cand;
        pick_valid = 1'b0;
        pick_idx   = '0;
        for (int unsigned i = 1; i <= NUM_LANES; i++) begin
            cand = (int'(last_q) + i) % NUM_LANES;
            if (!pick_valid && lane_done_i[cand]) begin
                pick_valid = 1'b1;
                pick_idx   = LANE_W'(cand);
            end
        end
    end

    // Both req and ack low before a new pick
    assign grant = (state_q == WB_IDLE) && !wb_req_o && !wb_ack_i && pick_valid;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q        <= WB_IDLE;
            wb_req_o       <= 1'b0;
            lane_release_o <= '0;
            last_q         <= LANE_W'(NUM_LANES - 1);
        end else begin
            lane_release_o <= '0;
            case (state_q)
                WB_IDLE: begin
                    if (grant) begin
                        wb_req_o <= 1'b1;
                        last_q   <= pick_idx;
                        state_q  <= WB_REQ;
                    end
                end
                WB_REQ: begin
                    // Lane is freed as req drops
                    if (wb_ack_i) begin
                        wb_req_o               <= 1'b0;
                        lane_release_o[last_q] <= 1'b1;
                        state_q                <= WB_ACK_LOW;
                    end
                end
                WB_ACK_LOW: begin
                    if (!wb_ack_i) begin
                        state_q <= WB_IDLE;
                    end
                end
                default: state_q <= WB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (grant) begin
            wb_data_o <= lane_result_i[pick_idx];
        end
    end

    // Served lane keeps its result unchanged while req is high
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        wb_req_o |-> lane_done_i[last_q] && wb_data_o == lane_result_i[last_q])
        else $error("wb_arbiter: writeback data no longer matches the served lane");

endmodule

// ==== hw/ex_stage.sv ====
`timescale 1ns/1ps

module ex_stage #(
    parameter int unsigned NUM_LANES = 4
) (
    input  logic             clk_i,
    input  logic             rst_ni,
    // Issue port, four-phase
    input  logic             issue_req_i,
    input  ex_pkg::fu_data_t issue_data_i,
    output logic             issue_ack_o,
    // Writeback port, four-phase
    output logic             wb_req_o,
    output ex_pkg::wb_data_t wb_data_o,
    input  logic             wb_ack_i
);
    import ex_pkg::*;

    logic [NUM_LANES-1:0]     lane_busy;
    logic [NUM_LANES-1:0]     lane_start;
    logic [NUM_LANES-1:0]     lane_done;
    logic [NUM_LANES-1:0]     lane_release;
    fu_data_t                 lane_data;
    wb_data_t [NUM_LANES-1:0] lane_result;

    issue_dispatch #(
        .NUM_LANES ( NUM_LANES )
    ) dispatch_i (
        .clk_i,
        .rst_ni,
        .issue_req_i,
        .issue_data_i,
        .issue_ack_o,
        .lane_busy_i  ( lane_busy  ),
        .lane_start_o ( lane_start ),
        .lane_data_o  ( lane_data  )
    );

    // ----------------------------------------
    // Identical execution lanes
    // ----------------------------------------
    for (genvar g = 0; g < NUM_LANES; g++) begin : gen_lane
        exec_lane lane_i (
            .clk_i,
            .rst_ni,
            .start_i   ( lane_start[g]   ),
            .op_i      ( lane_data       ),
            .release_i ( lane_release[g] ),
            .busy_o    ( lane_busy[g]    ),
            .done_o    ( lane_done[g]    ),
            .result_o  ( lane_result[g]  )
        );
    end

    wb_arbiter #(
        .NUM_LANES ( NUM_LANES )
    ) arbiter_i (
        .clk_i,
        .rst_ni,
        .lane_done_i    ( lane_done    ),
        .lane_result_i  ( lane_result  ),
        .lane_release_o ( lane_release ),
        .wb_req_o,
        .wb_data_o,
        .wb_ack_i
    );

endmodule

// ==== include/ex_tb_model.svh ====
`ifndef EX_TB_MODEL_SVH
`define EX_TB_MODEL_SVH

// ----------------------------------------
// Expected-result scoreboard
// ----------------------------------------

// Indexed by transaction ID
logic [ex_pkg::XLEN-1:0]             exp_result [2**ex_pkg::TRANS_ID_BITS];
ex_pkg::fu_op_e                      exp_op     [2**ex_pkg::TRANS_ID_BITS];
// One bit per ID still in flight
logic [2**ex_pkg::TRANS_ID_BITS-1:0] exp_outstanding;

// Reference model of one operation
function automatic logic [ex_pkg::XLEN-1:0] ex_model(
    input ex_pkg::fu_op_e          op,
    input logic [ex_pkg::XLEN-1:0] a,
    input logic [ex_pkg::XLEN-1:0] b
);
    logic [2*ex_pkg::XLEN-1:0] product;
    int unsigned               sh;
    sh      = b[$clog2(ex_pkg::XLEN)-1:0];
    product = {{ex_pkg::XLEN{1'b0}}, a} * {{ex_pkg::XLEN{1'b0}}, b};
    case (op)
        ex_pkg::ADD: return a + b;
        ex_pkg::SUB: return a - b;
        ex_pkg::AND: return a & b;
        ex_pkg::OR:  return a | b;
        ex_pkg::XOR: return a ^ b;
        ex_pkg::SLL: return a << sh;
        ex_pkg::SRL: return a >> sh;
        ex_pkg::SLT: return ($signed(a) < $signed(b)) ? 1 : 0;
        // Low word only
        ex_pkg::MUL: return product[ex_pkg::XLEN-1:0];
        default:     return '0;
    endcase
endfunction

`endif

// ==== dv/tb_ex_stage.sv ====
`timescale 1ns/1ps

module tb_ex_stage;
    import ex_pkg::*;

    `include "ex_tb_model.svh"

    localparam int unsigned NUM_LANES  = 4;
    localparam int unsigned WAIT_LIMIT = 300;
    localparam int unsigned NUM_RANDOM = 300;

    logic     clk_i;
    logic     rst_ni;
    logic     issue_req_i;
    fu_data_t issue_data_i;
    logic     issue_ack_o;
    logic     wb_req_o;
    wb_data_t wb_data_o;
    logic     wb_ack_i;

    int       seed;
    int       resp_seed;
    logic     hold_ack;
    logic     ack_prev;
    logic     req_prev;
    logic     wbreq_prev;
    logic     wback_prev;

    ex_stage #(
        .NUM_LANES ( NUM_LANES )
    ) dut_i (
        .clk_i,
        .rst_ni,
        .issue_req_i,
        .issue_data_i,
        .issue_ack_o,
        .wb_req_o,
        .wb_data_o,
        .wb_ack_i
    );

    always #5 clk_i = ~clk_i;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            report_failure($sformatf("error: %s expected %0h actual %0h",
                                     name, expected, actual));
        end
    endtask

    // ----------------------------------------
    // Issue side, one four-phase transfer
    // ----------------------------------------
    task automatic issue_op(input fu_op_e op, input logic [XLEN-1:0] a,
                            input logic [XLEN-1:0] b);
        int unsigned              waited;
        logic [TRANS_ID_BITS-1:0] id;
        waited = 0;
        while (&exp_outstanding) begin
            @(negedge clk_i);
            waited++;
            if (waited > WAIT_LIMIT) report_failure("no transaction ID came back in time");
        end
        id = TRANS_ID_BITS'($random(seed));
        while (exp_outstanding[id]) id = id + 1'b1;
        exp_result[id]       = ex_model(op, a, b);
        exp_op[id]           = op;
        exp_outstanding[id]  = 1'b1;
        issue_data_i.operator  = op;
        issue_data_i.trans_id  = id;
        issue_data_i.operand_a = a;
        issue_data_i.operand_b = b;
        issue_req_i = 1'b1;
        waited = 0;
        while (!issue_ack_o) begin
            @(negedge clk_i);
            waited++;
            if (waited > WAIT_LIMIT) report_failure("issue ack never rose");
        end
        issue_req_i = 1'b0;
        waited = 0;
        while (issue_ack_o) begin
            @(negedge clk_i);
            waited++;
            if (waited > WAIT_LIMIT) report_failure("issue ack never fell after req dropped");
        end
    endtask

    task automatic wait_drained();
        int unsigned waited;
        waited = 0;
        while (exp_outstanding != '0) begin
            @(negedge clk_i);
            waited++;
            if (waited > 4 * WAIT_LIMIT) report_failure("operations still outstanding");
        end
    endtask

    task automatic record_writeback(input wb_data_t got);
        check_value("writeback id outstanding", 1, exp_outstanding[got.trans_id]);
        check_value($sformatf("result %s id %0d", exp_op[got.trans_id].name(), got.trans_id),
                    exp_result[got.trans_id], got.result);
        exp_outstanding[got.trans_id] = 1'b0;
    endtask

    // ----------------------------------------
    // Writeback responder
    // ----------------------------------------
    always begin : wb_responder
        int unsigned waited;
        int unsigned delay;
        wb_data_t    got;
        @(negedge clk_i);
        if (rst_ni && wb_req_o) begin
            got    = wb_data_o;
            waited = 0;
            while (hold_ack) begin
                @(negedge clk_i);
                waited++;
                if (waited > WAIT_LIMIT) report_failure("writeback ack held back too long");
            end
            delay = $unsigned($random(resp_seed)) % 7;
            repeat (delay) @(negedge clk_i);
            check_value("writeback data stable", got, wb_data_o);
            record_writeback(got);
            wb_ack_i = 1'b1;
            waited   = 0;
            while (wb_req_o) begin
                @(negedge clk_i);
                waited++;
                if (waited > WAIT_LIMIT) report_failure("writeback req never fell after ack");
            end
            wb_ack_i = 1'b0;
        end
    end

    // Both handshakes must drop in the right order
    always @(posedge clk_i) begin : handshake_monitor
        if (rst_ni) begin
            if (ack_prev && !issue_ack_o) check_value("issue ack drop", 0, req_prev);
            if (wbreq_prev && !wb_req_o) check_value("writeback req drop", 1, wback_prev);
        end
        ack_prev   = issue_ack_o;
        req_prev   = issue_req_i;
        wbreq_prev = wb_req_o;
        wback_prev = wb_ack_i;
    end

    initial begin
        seed            = 32'hbe99adfa;
        resp_seed       = ~seed;
        clk_i           = 1'b0;
        rst_ni          = 1'b0;
        issue_req_i     = 1'b0;
        issue_data_i    = '0;
        wb_ack_i        = 1'b0;
        hold_ack        = 1'b0;
        exp_outstanding = '0;
        repeat (2) @(negedge clk_i);
        rst_ni = 1'b1;
        @(negedge clk_i);
        check_value("issue ack after reset", 0, issue_ack_o);
        check_value("writeback req after reset", 0, wb_req_o);

        // Every ALU opcode, then a few multiplies
        for (int k = 0; k < 8; k++) begin
            issue_op(fu_op_e'(k), $random(seed), $random(seed));
        end
        issue_op(MUL, 32'hffff_ffff, 32'hffff_ffff);
        issue_op(MUL, 32'h0001_0000, 32'h0001_0000);
        issue_op(MUL, $random(seed), $random(seed));
        wait_drained();

        for (int n = 0; n < NUM_RANDOM; n++) begin
            issue_op(fu_op_e'($unsigned($random(seed)) % 9), $random(seed), $random(seed));
        end
        wait_drained();

        // All lanes stuck on held writebacks
        hold_ack = 1'b1;
        repeat (NUM_LANES) issue_op(MUL, $random(seed), $random(seed));
        fork
            issue_op(ADD, $random(seed), $random(seed));
            begin
                repeat (XLEN + 10) begin
                    @(negedge clk_i);
                    check_value("issue stalled while lanes full", 0, issue_ack_o);
                end
                hold_ack = 1'b0;
            end
        join
        wait_drained();

        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+include
hw/ex_pkg.sv
hw/issue_dispatch.sv
hw/exec_lane.sv
hw/wb_arbiter.sv
hw/ex_stage.sv
dv/tb_ex_stage.sv

// ==== Makefile ====
TOP := tb_ex_stage

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -Wall -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f all.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log
